// ==== list.f ====
+incdir+src
+incdir+verif
src/softmax_data_pkg.sv
src/softmax_ctrl_pkg.sv
src/softmax_beat_counter.sv
src/softmax_row_store.sv
src/softmax_max_sum.sv
src/softmax_div_dispatch.sv
src/softmax_stream.sv
src/softmax_top.sv
verif/softmax_tb.sv

// ==== src/softmax_beat_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax beat counter
// Places accumulate and stream strobes in the block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

module softmax_beat_counter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    acc_en_i,
  input  logic                    stream_en_i,
  input  softmax_ctrl_pkg::tile_t tile_count_i,
  output softmax_ctrl_pkg::row_t  acc_row_o,
  output softmax_ctrl_pkg::beat_t acc_beat_o,
  output softmax_ctrl_pkg::tile_t acc_tile_o,
  output logic                    acc_last_o,
  output softmax_ctrl_pkg::row_t  stream_row_o,
  output softmax_ctrl_pkg::tile_t stream_tile_o
);

  localparam softmax_ctrl_pkg::row_t last_row = softmax_ctrl_pkg::row_t'(`SOFT_M - 1);
  localparam softmax_ctrl_pkg::beat_t last_beat =
    softmax_ctrl_pkg::beat_t'(`SOFT_M / `SOFT_N - 1);

  softmax_ctrl_pkg::row_t  acc_row_q;
  softmax_ctrl_pkg::row_t  stream_row_q;
  softmax_ctrl_pkg::beat_t acc_beat_q;
  softmax_ctrl_pkg::tile_t acc_tile_q;
  softmax_ctrl_pkg::tile_t stream_tile_q;
  softmax_ctrl_pkg::tile_t last_tile;

  // A tile count of zero wraps to the full tile range
  assign last_tile = tile_count_i - 1'b1;

  // Accumulate order is tile, then row, then beat
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_row_q  <= '0;
      acc_beat_q <= '0;
      acc_tile_q <= '0;
    end else if (acc_en_i) begin
      acc_beat_q <= acc_beat_q + 1'b1;
      if (acc_beat_q == last_beat) begin
        acc_beat_q <= '0;
        acc_row_q  <= acc_row_q + 1'b1;
        if (acc_row_q == last_row) begin
          acc_row_q  <= '0;
          acc_tile_q <= (acc_tile_q == last_tile) ? '0 : acc_tile_q + 1'b1;
        end
      end
    end
  end

  // Stream walks all tiles of a row before the next row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stream_row_q  <= '0;
      stream_tile_q <= '0;
    end else if (stream_en_i) begin
      stream_tile_q <= stream_tile_q + 1'b1;
      if (stream_tile_q == last_tile) begin
        stream_tile_q <= '0;
        stream_row_q  <= (stream_row_q == last_row) ? '0 : stream_row_q + 1'b1;
      end
    end
  end

  assign acc_row_o     = acc_row_q;
  assign acc_beat_o    = acc_beat_q;
  assign acc_tile_o    = acc_tile_q;
  assign acc_last_o    = (acc_tile_q == last_tile) && (acc_beat_q == last_beat);
  assign stream_row_o  = stream_row_q;
  assign stream_tile_o = stream_tile_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(acc_en_i && stream_en_i))
    else $error("accumulate and stream strobes overlap");

endmodule

// ==== src/softmax_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax configuration
// Tile size, lane counts, widths and divider setup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SOFTMAX_CONFIG_SVH
`define SOFTMAX_CONFIG_SVH

// Tile edge, also the stream lane count
`define SOFT_M 8

// Lanes per accumulate beat
`define SOFT_N 4

// Column tiles per block
`define SOFT_MAX_TILES 4

`define SOFT_SUM_W 16

// External dividers and the FIFO that feeds them
`define SOFT_NUM_DIV 2
`define SOFT_FIFO_DEPTH 8

// Divider numerator, the quotient takes half of it
`define SOFT_DIV_NUMER_W 16

`endif

// ==== src/softmax_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax control types
// Row, beat and tile counters, divider index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

package softmax_ctrl_pkg;

  typedef logic [$clog2(`SOFT_M)-1:0] row_t;
  typedef logic [$clog2(`SOFT_M / `SOFT_N)-1:0] beat_t;
  typedef logic [$clog2(`SOFT_MAX_TILES)-1:0] tile_t;

  // Sequence length up to the full block width
  typedef logic [$clog2(`SOFT_M * `SOFT_MAX_TILES):0] len_t;

  typedef logic [$clog2(`SOFT_NUM_DIV)-1:0] div_sel_t;

endpackage

// ==== src/softmax_data_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax data types
// Scores, shifts, sums and inverses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

package softmax_data_pkg;

  typedef logic signed [7:0] score_t;

  // 15 marks a lane that adds nothing
  typedef logic [3:0] shift_t;

  typedef logic [`SOFT_SUM_W-1:0] sum_t;
  typedef logic [`SOFT_DIV_NUMER_W/2-1:0] inv_t;
  typedef logic [7:0] out_t;

  // Shift approximation of exp(lo - hi), d / 32 rounded on bit 4
  function automatic shift_t shift_of(score_t hi, score_t lo);
    logic [7:0] diff;
    diff = hi - lo;
    return shift_t'(diff[7:5]) + shift_t'(diff[4]);
  endfunction

endpackage

// ==== src/softmax_div_dispatch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax division dispatch
// Sum FIFO, round-robin dividers, inverse writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

module softmax_div_dispatch (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       push_i,
  input  softmax_data_pkg::sum_t                     push_sum_i,
  input  logic [`SOFT_NUM_DIV-1:0]                   div_ready_i,
  input  logic [`SOFT_NUM_DIV-1:0]                   div_valid_i,
  input  softmax_data_pkg::inv_t [`SOFT_NUM_DIV-1:0] div_quot_i,
  output logic [`SOFT_NUM_DIV-1:0]                   div_valid_o,
  output logic [`SOFT_NUM_DIV-1:0]                   div_ready_o,
  output softmax_data_pkg::sum_t                     div_sum_o,
  output logic                                       inv_we_o,
  output softmax_ctrl_pkg::row_t                     inv_row_o,
  output softmax_data_pkg::inv_t                     inv_o,
  output logic                                       softmax_done_o
);

  localparam int unsigned ptr_w = $clog2(`SOFT_FIFO_DEPTH);
  localparam softmax_ctrl_pkg::div_sel_t last_div =
    softmax_ctrl_pkg::div_sel_t'(`SOFT_NUM_DIV - 1);
  localparam softmax_ctrl_pkg::row_t last_row = softmax_ctrl_pkg::row_t'(`SOFT_M - 1);

  softmax_data_pkg::sum_t     fifo_mem [`SOFT_FIFO_DEPTH];
  logic [ptr_w-1:0]           wr_ptr_q, rd_ptr_q;
  logic [ptr_w:0]             count_q;
  logic [$clog2(`SOFT_M):0]   owed_q;
  logic                       full, empty, pop, wb;
  softmax_ctrl_pkg::div_sel_t snd_q, rcv_q;
  softmax_ctrl_pkg::row_t     wb_row_q;
  logic                       done_q;

  assign full  = count_q == (ptr_w + 1)'(`SOFT_FIFO_DEPTH);
  assign empty = count_q == '0;
  assign pop   = !empty && div_ready_i[snd_q];
  // Only accept a quotient while one is owed
  assign wb    = div_valid_i[rcv_q] && (owed_q != '0);

  always_comb begin
    div_valid_o        = '0;
    div_ready_o        = '0;
    div_valid_o[snd_q] = !empty;
    div_ready_o[rcv_q] = owed_q != '0;
  end

  assign div_sum_o      = fifo_mem[rd_ptr_q];
  assign inv_we_o       = wb;
  assign inv_row_o      = wb_row_q;
  assign inv_o          = div_quot_i[rcv_q];
  assign softmax_done_o = done_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      fifo_mem[wr_ptr_q] <= push_sum_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      owed_q   <= '0;
      snd_q    <= '0;
      rcv_q    <= '0;
      wb_row_q <= '0;
      done_q   <= 1'b0;
    end else begin
      count_q <= count_q + push_i - pop;
      owed_q  <= owed_q + pop - wb;
      done_q  <= 1'b0;
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        snd_q    <= (snd_q == last_div) ? '0 : snd_q + 1'b1;
      end
      // Quotients come back in feed order, one row after another
      if (wb) begin
        rcv_q    <= (rcv_q == last_div) ? '0 : rcv_q + 1'b1;
        wb_row_q <= (wb_row_q == last_row) ? '0 : wb_row_q + 1'b1;
        done_q   <= wb_row_q == last_row;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full)
    else $error("row sum pushed into a full FIFO");

endmodule

// ==== src/softmax_max_sum.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax max and sum pipeline
// Running row maximum and shifted exponent sum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

module softmax_max_sum (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  acc_en_i,
  input  softmax_data_pkg::score_t [`SOFT_N-1:0] acc_score_i,
  input  logic [`SOFT_N-1:0]                    acc_mask_i,
  input  softmax_ctrl_pkg::row_t                acc_row_i,
  input  softmax_ctrl_pkg::beat_t               acc_beat_i,
  input  softmax_ctrl_pkg::tile_t               acc_tile_i,
  input  logic                                  acc_last_i,
  input  softmax_ctrl_pkg::len_t                seq_len_i,
  output softmax_ctrl_pkg::row_t                rd_row_o,
  input  softmax_data_pkg::score_t              rd_max_i,
  input  softmax_data_pkg::sum_t                rd_sum_i,
  output logic                                  wr_en_o,
  output softmax_ctrl_pkg::row_t                wr_row_o,
  output softmax_data_pkg::score_t              wr_max_o,
  output softmax_data_pkg::sum_t                wr_sum_o,
  output logic                                  push_o,
  output softmax_data_pkg::sum_t                push_sum_o
);

  logic                                   s1_valid_q, s2_valid_q;
  logic                                   s1_first_q, s1_last_q, s2_last_q;
  softmax_ctrl_pkg::row_t                 s1_row_q, s2_row_q;
  softmax_data_pkg::score_t [`SOFT_N-1:0] s1_score_q;
  logic [`SOFT_N-1:0]                     pad, s1_pad_q;
  softmax_data_pkg::score_t               old_max, new_max, s2_max_q;
  softmax_data_pkg::sum_t                 old_sum, s2_old_sum_q, s3_sum;
  softmax_data_pkg::shift_t [`SOFT_N-1:0] lane_shift, s2_shift_q;
  softmax_data_pkg::shift_t               sum_shift, s2_sum_shift_q;

  // S1 padding beyond the sequence or under the mask
  always_comb begin
    for (int i = 0; i < `SOFT_N; i++) begin
      pad[i] = acc_mask_i[i] ||
               (int'(acc_tile_i) * `SOFT_M + int'(acc_beat_i) * `SOFT_N + i >= int'(seq_len_i));
    end
  end

  assign rd_row_o = s1_row_q;

  // S2 picks the old state, S3 wins over the store for the same row
  always_comb begin
    if (s1_first_q) begin
      old_max = 8'sh80;
      old_sum = '0;
    end else if (s2_valid_q && s2_row_q == s1_row_q) begin
      old_max = s2_max_q;
      old_sum = s3_sum;
    end else begin
      old_max = rd_max_i;
      old_sum = rd_sum_i;
    end
    new_max = old_max;
    for (int i = 0; i < `SOFT_N; i++) begin
      if (!s1_pad_q[i] && s1_score_q[i] > new_max) begin
        new_max = s1_score_q[i];
      end
    end
    for (int i = 0; i < `SOFT_N; i++) begin
      lane_shift[i] = s1_pad_q[i] ? 4'hF : softmax_data_pkg::shift_of(new_max, s1_score_q[i]);
    end
    sum_shift = softmax_data_pkg::shift_of(new_max, old_max);
  end

  // S3 rescales the old sum and adds 256 >> shift per lane
  always_comb begin
    s3_sum = s2_old_sum_q >> s2_sum_shift_q;
    for (int i = 0; i < `SOFT_N; i++) begin
      s3_sum = s3_sum + (softmax_data_pkg::sum_t'(256) >> s2_shift_q[i]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= acc_en_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_row_q       <= acc_row_i;
    s1_first_q     <= (acc_tile_i == '0) && (acc_beat_i == '0);
    s1_last_q      <= acc_last_i;
    s1_score_q     <= acc_score_i;
    s1_pad_q       <= pad;
    s2_row_q       <= s1_row_q;
    s2_last_q      <= s1_last_q;
    s2_max_q       <= new_max;
    s2_old_sum_q   <= old_sum;
    s2_shift_q     <= lane_shift;
    s2_sum_shift_q <= sum_shift;
  end

  // Last beat keeps its maximum for streaming, the sum goes to division
  assign wr_en_o    = s2_valid_q;
  assign wr_row_o   = s2_row_q;
  assign wr_max_o   = s2_max_q;
  assign wr_sum_o   = s3_sum;
  assign push_o     = s2_valid_q && s2_last_q;
  assign push_sum_o = s3_sum;

endmodule

// ==== src/softmax_row_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax row store
// Per-row maximum and sum, later the inverse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

module softmax_row_store (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     acc_we_i,
  input  softmax_ctrl_pkg::row_t   acc_row_i,
  input  softmax_data_pkg::score_t acc_max_i,
  input  softmax_data_pkg::sum_t   acc_sum_i,
  input  logic                     inv_we_i,
  input  softmax_ctrl_pkg::row_t   inv_row_i,
  input  softmax_data_pkg::inv_t   inv_i,
  input  softmax_ctrl_pkg::row_t   acc_raddr_i,
  input  softmax_ctrl_pkg::row_t   stream_raddr_i,
  output softmax_data_pkg::score_t acc_max_o,
  output softmax_data_pkg::sum_t   acc_sum_o,
  output softmax_data_pkg::score_t stream_max_o,
  output softmax_data_pkg::inv_t   stream_inv_o
);

  softmax_data_pkg::score_t max_mem [`SOFT_M];
  softmax_data_pkg::sum_t   sum_mem [`SOFT_M];

  always_ff @(posedge clk_i) begin
    if (acc_we_i) begin
      max_mem[acc_row_i] <= acc_max_i;
      sum_mem[acc_row_i] <= acc_sum_i;
    end
    // Quotient replaces the finished sum
    if (inv_we_i) begin
      sum_mem[inv_row_i] <= softmax_data_pkg::sum_t'(inv_i);
    end
  end

  assign acc_max_o    = max_mem[acc_raddr_i];
  assign acc_sum_o    = sum_mem[acc_raddr_i];
  assign stream_max_o = max_mem[stream_raddr_i];
  assign stream_inv_o = softmax_data_pkg::inv_t'(sum_mem[stream_raddr_i]);

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(acc_we_i && inv_we_i && acc_row_i == inv_row_i))
    else $error("accumulate and inverse write hit the same row");

endmodule

// ==== src/softmax_stream.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax stream stage
// Scales one row segment by the row inverse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

module softmax_stream (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  stream_en_i,
  input  softmax_data_pkg::score_t [`SOFT_M-1:0] stream_score_i,
  input  softmax_ctrl_pkg::row_t                stream_row_i,
  input  softmax_ctrl_pkg::tile_t               stream_tile_i,
  input  softmax_ctrl_pkg::len_t                seq_len_i,
  input  softmax_data_pkg::score_t              row_max_i,
  input  softmax_data_pkg::inv_t                row_inv_i,
  output logic                                  stream_valid_o,
  output softmax_data_pkg::out_t [`SOFT_M-1:0]  stream_o
);

  softmax_data_pkg::out_t [`SOFT_M-1:0] lane_d, stream_q;
  logic                                 row_off;
  logic                                 valid_q;

  // Rows and columns past the sequence stream zeros
  always_comb begin
    row_off = int'(stream_row_i) >= int'(seq_len_i);
    for (int i = 0; i < `SOFT_M; i++) begin
      if (row_off || int'(stream_tile_i) * `SOFT_M + i >= int'(seq_len_i)) begin
        lane_d[i] = '0;
      end else begin
        lane_d[i] = softmax_data_pkg::out_t'(
          row_inv_i >> softmax_data_pkg::shift_of(row_max_i, stream_score_i[i]));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= stream_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stream_en_i) begin
      stream_q <= lane_d;
    end
  end

  assign stream_valid_o = valid_q;
  assign stream_o       = stream_q;

endmodule

// ==== src/softmax_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax top
// Integer softmax of one attention-score block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

module softmax_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  softmax_ctrl_pkg::len_t                     seq_len_i,
  input  softmax_ctrl_pkg::tile_t                    tile_count_i,
  input  logic                                       acc_en_i,
  input  softmax_data_pkg::score_t [`SOFT_N-1:0]      acc_score_i,
  input  logic [`SOFT_N-1:0]                         acc_mask_i,
  output logic [`SOFT_NUM_DIV-1:0]                   div_valid_o,
  input  logic [`SOFT_NUM_DIV-1:0]                   div_ready_i,
  output softmax_data_pkg::sum_t                     div_sum_o,
  input  logic [`SOFT_NUM_DIV-1:0]                   div_valid_i,
  output logic [`SOFT_NUM_DIV-1:0]                   div_ready_o,
  input  softmax_data_pkg::inv_t [`SOFT_NUM_DIV-1:0] div_quot_i,
  output logic                                       softmax_done_o,
  input  logic                                       stream_en_i,
  input  softmax_data_pkg::score_t [`SOFT_M-1:0]      stream_score_i,
  output logic                                       stream_valid_o,
  output softmax_data_pkg::out_t [`SOFT_M-1:0]        stream_o
);

  softmax_ctrl_pkg::row_t   acc_row, stream_row, rd_row, wr_row, inv_row;
  softmax_ctrl_pkg::beat_t  acc_beat;
  softmax_ctrl_pkg::tile_t  acc_tile, stream_tile;
  logic                     acc_last, wr_en, push, inv_we;
  softmax_data_pkg::score_t rd_max, wr_max, stream_max;
  softmax_data_pkg::sum_t   rd_sum, wr_sum, push_sum;
  softmax_data_pkg::inv_t   inv, stream_inv;

  softmax_beat_counter i_beat_counter (
    .clk_i, .rst_ni, .acc_en_i, .stream_en_i, .tile_count_i,
    .acc_row_o    (acc_row),
    .acc_beat_o   (acc_beat),
    .acc_tile_o   (acc_tile),
    .acc_last_o   (acc_last),
    .stream_row_o (stream_row),
    .stream_tile_o(stream_tile)
  );

  softmax_row_store i_row_store (
    .clk_i, .rst_ni,
    .acc_we_i      (wr_en),
    .acc_row_i     (wr_row),
    .acc_max_i     (wr_max),
    .acc_sum_i     (wr_sum),
    .inv_we_i      (inv_we),
    .inv_row_i     (inv_row),
    .inv_i         (inv),
    .acc_raddr_i   (rd_row),
    .stream_raddr_i(stream_row),
    .acc_max_o     (rd_max),
    .acc_sum_o     (rd_sum),
    .stream_max_o  (stream_max),
    .stream_inv_o  (stream_inv)
  );

  softmax_max_sum i_max_sum (
    .clk_i, .rst_ni, .acc_en_i, .acc_score_i, .acc_mask_i, .seq_len_i,
    .acc_row_i (acc_row),
    .acc_beat_i(acc_beat),
    .acc_tile_i(acc_tile),
    .acc_last_i(acc_last),
    .rd_row_o  (rd_row),
    .rd_max_i  (rd_max),
    .rd_sum_i  (rd_sum),
    .wr_en_o   (wr_en),
    .wr_row_o  (wr_row),
    .wr_max_o  (wr_max),
    .wr_sum_o  (wr_sum),
    .push_o    (push),
    .push_sum_o(push_sum)
  );

  softmax_div_dispatch i_div_dispatch (
    .clk_i, .rst_ni, .div_ready_i, .div_valid_i, .div_quot_i,
    .div_valid_o, .div_ready_o, .div_sum_o, .softmax_done_o,
    .push_i    (push),
    .push_sum_i(push_sum),
    .inv_we_o  (inv_we),
    .inv_row_o (inv_row),
    .inv_o     (inv)
  );

  softmax_stream i_stream (
    .clk_i, .rst_ni, .stream_en_i, .stream_score_i, .seq_len_i,
    .stream_valid_o, .stream_o,
    .stream_row_i (stream_row),
    .stream_tile_i(stream_tile),
    .row_max_i    (stream_max),
    .row_inv_i    (stream_inv)
  );

endmodule

// ==== verif/softmax_tb_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax reference model
// Shift rule, divider quotient, LFSR and row model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SOFTMAX_TB_MODEL_SVH
`define SOFTMAX_TB_MODEL_SVH

logic [31:0] lfsr_q = 32'h335779cb;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] lfsr_bits(int n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int i = 0; i < n; i++) begin
    fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    v     = {v[30:0], fb};
  end
  return v;
endfunction

// Difference is taken on 8 bits, then d / 32 plus bit 4
function automatic int shift_amt(int hi, int lo);
  int d;
  d = (hi - lo) & 255;
  return d / 32 + ((d >> 4) & 1);
endfunction

function automatic int quotient_of(int sum);
  int q;
  if (sum == 0) begin
    return 255;
  end
  q = 65535 / sum;
  return (q > 255) ? 255 : q;
endfunction

// Row maximum and sum, beat by beat in accumulate order
function automatic void model_block(int len, int tiles);
  int col;
  int mx;
  int new_max;
  int sum;
  for (int r = 0; r < `SOFT_M; r++) begin
    mx  = -128;
    sum = 0;
    for (int t = 0; t < tiles; t++) begin
      for (int b = 0; b < `SOFT_M / `SOFT_N; b++) begin
        new_max = mx;
        for (int i = 0; i < `SOFT_N; i++) begin
          col = t * `SOFT_M + b * `SOFT_N + i;
          if (col < len && !mask_mem[r][col] && int'(score_mem[r][col]) > new_max) begin
            new_max = int'(score_mem[r][col]);
          end
        end
        sum = sum >> shift_amt(new_max, mx);
        for (int i = 0; i < `SOFT_N; i++) begin
          col = t * `SOFT_M + b * `SOFT_N + i;
          if (col < len && !mask_mem[r][col]) begin
            sum = sum + (256 >> shift_amt(new_max, int'(score_mem[r][col])));
          end
        end
        sum = sum & 16'hffff;
        mx  = new_max;
      end
    end
    model_max[r] = mx;
    model_sum[r] = sum;
    model_inv[r] = quotient_of(sum);
  end
endfunction

function automatic int expected_lane(int r, int col);
  return (model_inv[r] >> shift_amt(model_max[r], int'(score_mem[r][col]))) & 255;
endfunction

`endif

// ==== verif/softmax_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax testbench
// Block tests from a data file, divider responder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "softmax_config.svh"

module softmax_tb;

  logic                                       clk;
  logic                                       rst_n;
  softmax_ctrl_pkg::len_t                     seq_len;
  softmax_ctrl_pkg::tile_t                    tile_count;
  logic                                       acc_en;
  softmax_data_pkg::score_t [`SOFT_N-1:0]     acc_score;
  logic [`SOFT_N-1:0]                         acc_mask;
  logic [`SOFT_NUM_DIV-1:0]                   sum_valid;
  logic [`SOFT_NUM_DIV-1:0]                   sum_ready;
  softmax_data_pkg::sum_t                     div_sum;
  logic [`SOFT_NUM_DIV-1:0]                   quot_valid;
  logic [`SOFT_NUM_DIV-1:0]                   quot_ready;
  softmax_data_pkg::inv_t [`SOFT_NUM_DIV-1:0] quot;
  logic                                       done;
  logic                                       stream_en;
  softmax_data_pkg::score_t [`SOFT_M-1:0]     stream_score;
  logic                                       stream_valid;
  softmax_data_pkg::out_t [`SOFT_M-1:0]       stream_out;

  softmax_data_pkg::score_t score_mem [`SOFT_M][`SOFT_M * `SOFT_MAX_TILES];
  logic                     mask_mem [`SOFT_M][`SOFT_M * `SOFT_MAX_TILES];
  int                       model_max [`SOFT_M];
  int                       model_sum [`SOFT_M];
  int                       model_inv [`SOFT_M];

  // Divider responder, entries kept in feed order
  int pend_div[$];
  int pend_quot[$];
  int pend_due[$];
  int got_sums[$];
  int got_quots[$];
  int cycle, done_count, wb_count, wb_at_done;

  string t_name[$];
  string t_mode[$];
  int    t_len[$], t_tiles[$], t_arg[$], t_inv[$], t_out[$];
  int    total_beats, checks, errs, total_checks, total_errs;

  `include "softmax_tb_model.svh"

  softmax_top dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .seq_len_i     (seq_len),
    .tile_count_i  (tile_count),
    .acc_en_i      (acc_en),
    .acc_score_i   (acc_score),
    .acc_mask_i    (acc_mask),
    .div_valid_o   (sum_valid),
    .div_ready_i   (sum_ready),
    .div_sum_o     (div_sum),
    .div_valid_i   (quot_valid),
    .div_ready_o   (quot_ready),
    .div_quot_i    (quot),
    .softmax_done_o(done),
    .stream_en_i   (stream_en),
    .stream_score_i(stream_score),
    .stream_valid_o(stream_valid),
    .stream_o      (stream_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    wait (total_beats > 0);
    #(8 * 200 * total_beats);
    $display("watchdog expired before the tests finished");
    $display("Errors found");
    $finish;
  end

  task automatic report_mismatch(int k, string what, int exp, int act);
    $display("FAIL %s %s expected %0d actual %0d", t_name[k], what, exp, act);
    errs++;
  endtask

  task automatic report_problem(int k, string what);
    $display("%s: %s", t_name[k], what);
    errs++;
  endtask

  task automatic respond_dividers();
    int          d;
    int          s;
    logic [31:0] bits;
    // Only the oldest quotient may answer
    quot_valid = '0;
    if (pend_div.size() > 0 && pend_due[0] <= cycle) begin
      d             = pend_div[0];
      quot_valid[d] = 1'b1;
      quot[d]       = softmax_data_pkg::inv_t'(pend_quot[0]);
      if (quot_ready[d]) begin
        got_quots.push_back(pend_quot[0]);
        void'(pend_div.pop_front());
        void'(pend_quot.pop_front());
        void'(pend_due.pop_front());
        wb_count++;
      end
    end
    bits      = lfsr_bits(`SOFT_NUM_DIV);
    sum_ready = bits[`SOFT_NUM_DIV-1:0];
    for (int i = 0; i < `SOFT_NUM_DIV; i++) begin
      if (sum_valid[i] && sum_ready[i]) begin
        s = int'(div_sum);
        got_sums.push_back(s);
        pend_div.push_back(i);
        pend_quot.push_back(quotient_of(s));
        pend_due.push_back(cycle + 1 + int'(lfsr_bits(2)));
      end
    end
  endtask

  // Outputs are sampled on the falling edge, then inputs change
  task automatic tick();
    @(negedge clk);
    cycle++;
    if (done) begin
      done_count++;
      wb_at_done = wb_count;
    end
    respond_dividers();
  endtask

  task automatic load_tests();
    int    fd, n, len, tiles, arg, inv, out;
    string line, name, mode;
    fd = $fopen("verif/softmax_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %d %d %s %h %d %d", name, len, tiles, mode, arg, inv, out);
          if (n == 7) begin
            t_name.push_back(name);
            t_len.push_back(len);
            t_tiles.push_back(tiles);
            t_mode.push_back(mode);
            t_arg.push_back(arg);
            t_inv.push_back(inv);
            t_out.push_back(out);
            total_beats += `SOFT_M * (`SOFT_M / `SOFT_N) * tiles;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic fill_block(int k);
    for (int r = 0; r < `SOFT_M; r++) begin
      for (int c = 0; c < `SOFT_M * `SOFT_MAX_TILES; c++) begin
        mask_mem[r][c]  = 1'b0;
        score_mem[r][c] = '0;
        if (c < t_tiles[k] * `SOFT_M) begin
          if (t_mode[k] == "const") begin
            score_mem[r][c] = softmax_data_pkg::score_t'(t_arg[k]);
          end else begin
            score_mem[r][c] = softmax_data_pkg::score_t'(lfsr_bits(8));
          end
          if (t_mode[k] == "mask") begin
            mask_mem[r][c] = t_arg[k][c % 8];
          end
        end
      end
    end
  endtask

  // Tile, then row, then beat, one beat per cycle
  task automatic drive_accumulate(int k);
    int col;
    for (int t = 0; t < t_tiles[k]; t++) begin
      for (int r = 0; r < `SOFT_M; r++) begin
        for (int b = 0; b < `SOFT_M / `SOFT_N; b++) begin
          acc_en = 1'b1;
          for (int i = 0; i < `SOFT_N; i++) begin
            col          = t * `SOFT_M + b * `SOFT_N + i;
            acc_score[i] = score_mem[r][col];
            acc_mask[i]  = mask_mem[r][col];
          end
          tick();
        end
      end
    end
    acc_en   = 1'b0;
    acc_mask = '0;
  endtask

  task automatic drive_stream(int k);
    int col;
    int exp;
    for (int r = 0; r < `SOFT_M; r++) begin
      for (int t = 0; t < t_tiles[k]; t++) begin
        stream_en = 1'b1;
        for (int i = 0; i < `SOFT_M; i++) begin
          stream_score[i] = score_mem[r][t * `SOFT_M + i];
        end
        tick();
        stream_en = 1'b0;
        checks++;
        if (!stream_valid) begin
          report_problem(k, "stream output not valid one cycle after the strobe");
        end
        for (int i = 0; i < `SOFT_M; i++) begin
          col = t * `SOFT_M + i;
          if (r >= t_len[k] || col >= t_len[k]) begin
            exp = 0;
          end else if (t_mode[k] == "const") begin
            exp = t_out[k];
          end else begin
            exp = expected_lane(r, col);
          end
          checks++;
          if (int'(stream_out[i]) != exp) begin
            report_mismatch(k, $sformatf("row %0d col %0d", r, col), exp, int'(stream_out[i]));
          end
        end
      end
    end
    tick();
    if (stream_valid) begin
      report_problem(k, "stream output stayed valid without a strobe");
    end
  endtask

  task automatic run_test(int k);
    int waited;
    errs       = 0;
    checks     = 0;
    done_count = 0;
    wb_count   = 0;
    wb_at_done = 0;
    got_sums.delete();
    got_quots.delete();
    fill_block(k);
    model_block(t_len[k], t_tiles[k]);
    seq_len    = softmax_ctrl_pkg::len_t'(t_len[k]);
    tile_count = softmax_ctrl_pkg::tile_t'(t_tiles[k]);
    drive_accumulate(k);
    waited = 0;
    while (done_count == 0 && waited < 200 * `SOFT_M) begin
      tick();
      waited++;
    end
    if (done_count == 0) begin
      report_problem(k, "no done pulse after the last accumulate beat");
    end else begin
      checks++;
      if (wb_at_done != `SOFT_M) begin
        report_problem(k, "done pulse came before all quotients were accepted");
      end
      if (got_sums.size() != `SOFT_M) begin
        report_problem(k, $sformatf("%0d row sums reached the dividers", got_sums.size()));
      end
      for (int r = 0; r < got_sums.size() && r < `SOFT_M; r++) begin
        checks++;
        if (got_sums[r] != model_sum[r]) begin
          report_mismatch(k, $sformatf("row %0d sum", r), model_sum[r], got_sums[r]);
        end
      end
      for (int r = 0; r < got_quots.size() && t_mode[k] == "const"; r++) begin
        checks++;
        if (got_quots[r] != t_inv[k]) begin
          report_mismatch(k, $sformatf("row %0d inverse", r), t_inv[k], got_quots[r]);
        end
      end
      repeat (4) tick();
      drive_stream(k);
    end
    repeat (4) tick();
    if (done_count > 1) begin
      report_problem(k, $sformatf("%0d done pulses for one block", done_count));
    end
    $display("test %s: %0d checks, %0d errors", t_name[k], checks, errs);
    total_checks += checks;
    total_errs   += errs;
  endtask

  initial begin
    rst_n        = 1'b0;
    seq_len      = '0;
    tile_count   = '0;
    acc_en       = 1'b0;
    acc_score    = '0;
    acc_mask     = '0;
    sum_ready    = '0;
    quot_valid   = '0;
    quot         = '0;
    stream_en    = 1'b0;
    stream_score = '0;
    load_tests();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    if (t_name.size() == 0) begin
      $display("no tests were read from the test data file");
      total_errs++;
    end else begin
      for (int k = 0; k < t_name.size(); k++) begin
        run_test(k);
      end
    end
    $display("tests %0d, checks %0d, errors %0d", t_name.size(), total_checks, total_errs);
    if (total_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verif/softmax_testdata.txt ====
# name seq_len tiles mode arg_hex exp_inv exp_out
# const: all scores arg; rand: LFSR scores; mask: LFSR scores, masked where arg bit (col % 8) is set
c_full8    8 1 const 10 31 31
c_pad3     3 1 const 40 85 85
c_pad5     5 1 const 05 51 51
c_two12   12 2 const f0 21 21
c_three20 20 3 const 80 12 12
c_four32  32 4 const 7f 7 7
r_one8     8 1 rand 00 0 0
r_two13   13 2 rand 00 0 0
r_four27  27 4 rand 00 0 0
r_four32  32 4 rand 00 0 0
m_half16  16 2 mask 55 0 0
m_edge29  29 4 mask 81 0 0
m_all8     8 1 mask ff 0 0
